//--- vga_pkg.sv
package vga_pkg;

  // ########################################
  // apb slave
  // ########################################

  typedef enum logic [1:0] {
    idle   = 2'd0, // waiting for a setup phase
    access = 2'd1  // single access cycle, pready high
  } apb_state_t;

  localparam logic [31:0] ctrl_addr = 32'h211F_FFF4; // control register, bit 0 is enable

  // ########################################
  // pixel format
  // ########################################

  localparam int pixel_width  = 24; // packed rgb word
  localparam int colour_width = 8;  // per channel

  localparam int red_lsb   = 16; // red in 23:16
  localparam int green_lsb = 8;  // green in 15:8
  localparam int blue_lsb  = 0;  // blue in 7:0

endpackage

//--- apb_fb_regs.sv
`timescale 1ns/1ps

module apb_fb_regs #(
  parameter int fb_depth = 307200,
  localparam int fb_addr_width = $clog2(fb_depth)
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [31:0]                      paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [31:0]                      pwdata,
  output logic                             pready,
  output logic [31:0]                      prdata,
  output logic                             pslverr,
  output logic                             enable,
  output logic                             fb_we,
  output logic [fb_addr_width-1:0]         fb_waddr,
  output logic [vga_pkg::pixel_width-1:0]  fb_wdata
);

  vga_pkg::apb_state_t state;

  logic ctrl_hit;
  logic fb_hit;
  logic done;

  // ########################################
  // handshake
  // ########################################

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= vga_pkg::idle;
    end else begin
      case (state)
        vga_pkg::idle: begin
          if (psel && !penable) begin
            state <= vga_pkg::access; // setup phase seen
          end
        end
        vga_pkg::access: begin
          state <= vga_pkg::idle; // never more than one wait-free access
        end
        default: begin
          state <= vga_pkg::idle;
        end
      endcase
    end
  end

  assign pready = (state == vga_pkg::access);
  assign done   = pready && psel && penable;

  // ########################################
  // decode
  // ########################################

  assign ctrl_hit = (paddr == vga_pkg::ctrl_addr);
  assign fb_hit   = !ctrl_hit && ({2'b00, paddr[31:2]} < 32'(fb_depth)); // word index

  assign pslverr = pready && psel && !ctrl_hit && !fb_hit;
  assign prdata  = (pready && !pwrite && ctrl_hit) ? {31'b0, enable} : 32'b0;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      enable <= 1'b0;
    end else if (done && pwrite && ctrl_hit) begin
      enable <= pwdata[0];
    end
  end

  // framebuffer write lands on the completing edge
  assign fb_we    = done && pwrite && fb_hit;
  assign fb_waddr = paddr[fb_addr_width+1:2];
  assign fb_wdata = pwdata[vga_pkg::pixel_width-1:0]; // upper byte dropped

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
  parameter int depth = 307200,
  localparam int addr_width = $clog2(depth)
) (
  input  logic                             clock,
  input  logic                             we,
  input  logic [addr_width-1:0]            waddr,
  input  logic [vga_pkg::pixel_width-1:0]  wdata,
  input  logic [addr_width-1:0]            raddr,
  output logic [vga_pkg::pixel_width-1:0]  rdata
);

  logic [vga_pkg::pixel_width-1:0] mem [depth];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // same-address read during a write returns the old word
  always_ff @(posedge clock) begin
    rdata <= mem[raddr];
  end

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int h_sync  = 96,
  parameter int h_back  = 48,
  parameter int h_disp  = 640,
  parameter int h_front = 16,
  parameter int v_sync  = 2,
  parameter int v_back  = 33,
  parameter int v_disp  = 480,
  parameter int v_front = 10
) (
  input  logic clock,
  input  logic reset,
  input  logic enable,
  output logic hsync_raw,
  output logic vsync_raw,
  output logic active,
  output logic frame_start
);

  localparam int h_total = h_sync + h_back + h_disp + h_front;
  localparam int v_total = v_sync + v_back + v_disp + v_front;
  localparam int hw      = $clog2(h_total + 1);
  localparam int vw      = $clog2(v_total + 1);

  localparam logic [hw-1:0] h_last     = hw'(h_total - 1);
  localparam logic [hw-1:0] h_sync_end = hw'(h_sync);
  localparam logic [hw-1:0] h_act_lo   = hw'(h_sync + h_back);
  localparam logic [hw-1:0] h_act_hi   = hw'(h_sync + h_back + h_disp);

  localparam logic [vw-1:0] v_last     = vw'(v_total - 1);
  localparam logic [vw-1:0] v_sync_end = vw'(v_sync);
  localparam logic [vw-1:0] v_act_lo   = vw'(v_sync + v_back);
  localparam logic [vw-1:0] v_act_hi   = vw'(v_sync + v_back + v_disp);

  logic [hw-1:0] h_cnt;
  logic [vw-1:0] v_cnt;
  logic          line_end;
  logic          h_win;
  logic          v_win;

  // ########################################
  // counters
  // ########################################

  assign line_end = (h_cnt == h_last);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable) begin
      h_cnt <= '0; // parked at frame origin
      v_cnt <= '0;
    end else begin
      h_cnt <= line_end ? '0 : h_cnt + 1'b1;
      if (line_end) begin
        v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
      end
    end
  end

  // ########################################
  // window compares
  // ########################################

  assign h_win = (h_cnt >= h_act_lo) && (h_cnt < h_act_hi);
  assign v_win = (v_cnt >= v_act_lo) && (v_cnt < v_act_hi);

  assign hsync_raw   = !(enable && (h_cnt < h_sync_end)); // active low
  assign vsync_raw   = !(enable && (v_cnt < v_sync_end));
  assign active      = enable && h_win && v_win;
  assign frame_start = enable && (h_cnt == '0) && (v_cnt == '0);

endmodule

//--- pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch #(
  parameter int fb_depth = 307200,
  localparam int fb_addr_width = $clog2(fb_depth)
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              hsync_raw,
  input  logic                              vsync_raw,
  input  logic                              active,
  input  logic                              frame_start,
  input  logic [vga_pkg::pixel_width-1:0]   fb_rdata,
  output logic [fb_addr_width-1:0]          fb_raddr,
  output logic                              vga_hsync,
  output logic                              vga_vsync,
  output logic                              vga_valid,
  output logic [vga_pkg::colour_width-1:0]  vga_r,
  output logic [vga_pkg::colour_width-1:0]  vga_g,
  output logic [vga_pkg::colour_width-1:0]  vga_b
);

  localparam logic [fb_addr_width-1:0] last_addr = fb_addr_width'(fb_depth - 1);

  // ########################################
  // read address
  // ########################################

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      fb_raddr <= '0;
    end else if (frame_start) begin
      fb_raddr <= '0;
    end else if (active) begin
      fb_raddr <= (fb_raddr == last_addr) ? '0 : fb_raddr + 1'b1; // next pixel
    end
  end

  // sync and valid delayed to meet the memory read
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_valid <= 1'b0;
    end else begin
      vga_hsync <= hsync_raw;
      vga_vsync <= vsync_raw;
      vga_valid <= active;
    end
  end

  assign vga_r = vga_valid ? fb_rdata[vga_pkg::red_lsb   +: vga_pkg::colour_width] : '0;
  assign vga_g = vga_valid ? fb_rdata[vga_pkg::green_lsb +: vga_pkg::colour_width] : '0;
  assign vga_b = vga_valid ? fb_rdata[vga_pkg::blue_lsb  +: vga_pkg::colour_width] : '0;

endmodule

//--- vga_top_apb.sv
`timescale 1ns/1ps

module vga_top_apb #(
  parameter int h_sync  = 96,
  parameter int h_back  = 48,
  parameter int h_disp  = 640,
  parameter int h_front = 16,
  parameter int v_sync  = 2,
  parameter int v_back  = 33,
  parameter int v_disp  = 480,
  parameter int v_front = 10
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [31:0]                       paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [31:0]                       pwdata,
  output logic                              pready,
  output logic [31:0]                       prdata,
  output logic                              pslverr,
  output logic                              vga_hsync,
  output logic                              vga_vsync,
  output logic                              vga_valid,
  output logic [vga_pkg::colour_width-1:0]  vga_r,
  output logic [vga_pkg::colour_width-1:0]  vga_g,
  output logic [vga_pkg::colour_width-1:0]  vga_b
);

  localparam int fb_depth      = h_disp * v_disp; // one word per visible pixel
  localparam int fb_addr_width = $clog2(fb_depth);

  logic                            enable;
  logic                            fb_we;
  logic [fb_addr_width-1:0]        fb_waddr;
  logic [vga_pkg::pixel_width-1:0] fb_wdata;
  logic [fb_addr_width-1:0]        fb_raddr;
  logic [vga_pkg::pixel_width-1:0] fb_rdata;
  logic                            hsync_raw;
  logic                            vsync_raw;
  logic                            active;
  logic                            frame_start;

  apb_fb_regs #(.fb_depth(fb_depth)) apb_fb_regs_i (
    .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .pready, .prdata, .pslverr, .enable, .fb_we, .fb_waddr, .fb_wdata
  );

  frame_buffer #(.depth(fb_depth)) frame_buffer_i (
    .clock,
    .we    (fb_we),
    .waddr (fb_waddr),
    .wdata (fb_wdata),
    .raddr (fb_raddr),
    .rdata (fb_rdata)
  );

  vga_timing #(
    .h_sync (h_sync), .h_back (h_back), .h_disp (h_disp), .h_front (h_front),
    .v_sync (v_sync), .v_back (v_back), .v_disp (v_disp), .v_front (v_front)
  ) vga_timing_i (
    .clock, .reset, .enable, .hsync_raw, .vsync_raw, .active, .frame_start
  );

  pixel_fetch #(.fb_depth(fb_depth)) pixel_fetch_i (
    .clock, .reset, .hsync_raw, .vsync_raw, .active, .frame_start, .fb_rdata,
    .fb_raddr, .vga_hsync, .vga_vsync, .vga_valid, .vga_r, .vga_g, .vga_b
  );

endmodule

//--- vga_chk.sv
`timescale 1ns/1ps

module vga_chk (
  input logic                             clock,
  input logic                             reset,
  input logic                             penable,
  input logic                             pready,
  input logic                             pslverr,
  input logic                             vga_valid,
  input logic [vga_pkg::colour_width-1:0] vga_r,
  input logic [vga_pkg::colour_width-1:0] vga_g,
  input logic [vga_pkg::colour_width-1:0] vga_b
);

  // ########################################
  // apb
  // ########################################

  slverr_in_access: assert property (@(posedge clock) disable iff (reset)
    pslverr |-> (pready && penable))
    else $error("pslverr raised outside the access cycle");

  single_ready: assert property (@(posedge clock) disable iff (reset) !(pready && $past(pready)))
    else $error("pready held high for two cycles");

  // blanking must carry black
  blank_rgb: assert property (@(posedge clock) disable iff (reset)
    !vga_valid |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
    else $error("rgb not zero while vga_valid is low");

endmodule

bind vga_top_apb vga_chk vga_chk_i (
  .clock (clock), .reset (reset), .penable (penable), .pready (pready), .pslverr (pslverr),
  .vga_valid (vga_valid), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
);

//--- tb_vga.sv
`timescale 1ns/1ps

module tb_vga;

  localparam int h_sync   = 4;
  localparam int v_sync   = 1;
  localparam int h_total  = 16; // 4 sync + 2 back + 8 disp + 2 front
  localparam int fb_words = 32; // 8 x 4 visible
  localparam int aw       = 5;
  localparam int limit    = 2000; // cycles per wait
  localparam logic [31:0] ctrl = vga_pkg::ctrl_addr;

  logic clock, reset, psel, penable, pwrite;
  logic [31:0] paddr, pwdata, prdata;
  logic pready, pslverr, vga_hsync, vga_vsync, vga_valid;
  logic [7:0] vga_r, vga_g, vga_b;
  logic [31:0] model [fb_words];
  logic [31:0] lfsr;
  logic check_on, frame_checked, h_armed, prev_h, prev_v;
  logic [23:0] want;
  int pix_n, h_low, h_per, v_low, frames_done, mon_errors, errors, timeouts;

  vga_top_apb #(
    .h_sync (4), .h_back (2), .h_disp (8), .h_front (2),
    .v_sync (1), .v_back (1), .v_disp (4), .v_front (1)
  ) vga_top_apb_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0); // galois taps 32,22,2,1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] w);
    w = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [23:0] expected_rgb(input int n);
    return {model[n[aw-1:0]][23:16], model[n[aw-1:0]][15:8], model[n[aw-1:0]][7:0]};
  endfunction

  task automatic finish_run();
    $display("errors %0d, timeouts %0d, frames %0d", errors + mon_errors, timeouts, frames_done);
    if (errors + mon_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp_data, input logic exp_err);
    int t;
    @(negedge clock);
    psel = 1'b1; // setup phase
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clock);
    penable = 1'b1;
    t = 0;
    while (!pready && t < limit) begin
      @(negedge clock);
      t++;
    end
    if (!pready) timed_out("pready");
    assert (pslverr == exp_err) else begin
      errors++;
      $display("error pslverr at %h: got %h expected %h", addr, pslverr, exp_err);
    end
    assert (wr || prdata == exp_data) else begin
      errors++;
      $display("error prdata at %h: got %h expected %h", addr, prdata, exp_data);
    end
    @(negedge clock);
    assert (!pready) else begin
      errors++;
      $display("pready stayed high after the access cycle");
    end
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic fb_write(input int n, input logic [31:0] data);
    model[n[aw-1:0]] = data;
    apb_xfer(1'b1, 32'(n * 4), data, 32'h0, 1'b0);
  endtask

  task automatic set_checking(input logic on);
    @(posedge clock); // monitor samples on the other edge
    check_on = on;
  endtask

  task automatic wait_frames(input int count);
    int target;
    int t;
    @(posedge clock);
    target = frames_done + count;
    t = 0;
    while (frames_done < target && t < limit) begin
      @(posedge clock);
      t++;
    end
    if (frames_done < target) timed_out("checked frames");
  endtask

  task automatic wait_video(input logic running, input string what);
    logic hit;
    int t;
    hit = 1'b0;
    t = 0;
    while (!hit && t < limit) begin
      @(negedge clock);
      t++;
      hit = running ? vga_valid : (!vga_valid && vga_hsync && vga_vsync);
    end
    if (!hit) timed_out(what);
  endtask

  task automatic check_idle(input int cycles, input string when);
    repeat (cycles) begin
      @(negedge clock);
      assert (!vga_valid && vga_hsync && vga_vsync && {vga_r, vga_g, vga_b} == 24'h0) else begin
        errors++;
        $display("video outputs not idle %s", when);
      end
    end
  endtask

  // ########################################
  // monitor
  // ########################################

  always @(negedge clock) begin
    if (!check_on) begin
      frame_checked = 1'b0;
      h_armed = 1'b0;
    end
    if (prev_h && !vga_hsync) begin
      assert (!h_armed || h_per == h_total) else begin
        mon_errors++;
        $display("error hsync period: got %h expected %h", h_per, h_total);
      end
      h_per = 0;
      h_low = 0;
      h_armed = check_on;
    end
    assert (!(h_armed && !prev_h && vga_hsync) || h_low == h_sync) else begin
      mon_errors++;
      $display("error hsync low: got %h expected %h", h_low, h_sync);
    end
    if (prev_v && !vga_vsync) begin
      if (frame_checked) begin
        assert (pix_n == fb_words) else begin
          mon_errors++;
          $display("error valid pixel count: got %h expected %h", pix_n, fb_words);
        end
        frames_done++;
      end
      pix_n = 0;
      v_low = 0;
      frame_checked = check_on;
    end
    assert (!(frame_checked && !prev_v && vga_vsync) || v_low == v_sync * h_total) else begin
      mon_errors++;
      $display("error vsync low: got %h expected %h", v_low, v_sync * h_total);
    end
    if (vga_valid && frame_checked) begin
      want = (pix_n < fb_words) ? expected_rgb(pix_n) : 24'h0;
      assert ({vga_r, vga_g, vga_b} == want) else begin
        mon_errors++;
        $display("error vga_r/g/b pixel %0d: got %h %h %h expected %h %h %h", pix_n,
                 vga_r, vga_g, vga_b, want[23:16], want[15:8], want[7:0]);
      end
      pix_n++;
    end
    if (!vga_hsync) h_low++;
    if (!vga_vsync) v_low++;
    h_per++;
    prev_h = vga_hsync;
    prev_v = vga_vsync;
  end

  // ########################################
  // sequence
  // ########################################

  initial begin
    logic [31:0] w;
    {errors, mon_errors, timeouts, frames_done, pix_n, h_low, h_per, v_low} = '0;
    lfsr = 32'h591f_4606;
    {check_on, frame_checked, h_armed} = 3'b000;
    {prev_h, prev_v} = 2'b11;
    reset = 1'b1;
    {psel, penable, pwrite} = 3'b000;
    paddr = '0;
    pwdata = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_idle(40, "after reset");
    assert (!pready && !pslverr) else begin
      errors++;
      $display("apb outputs active after reset");
    end
    apb_xfer(1'b1, ctrl, 32'h1, 32'h0, 1'b0);
    apb_xfer(1'b0, ctrl, 32'h0, 32'h1, 1'b0);
    apb_xfer(1'b1, ctrl, 32'h0, 32'h0, 1'b0);
    apb_xfer(1'b0, ctrl, 32'h0, 32'h0, 1'b0);
    for (int i = 0; i < fb_words; i++) begin
      rand_bits(32, w);
      fb_write(i, w);
    end
    apb_xfer(1'b1, 32'(fb_words * 4), 32'hdead_beef, 32'h0, 1'b1); // just past the memory
    apb_xfer(1'b0, 32'(fb_words * 4), 32'h0, 32'h0, 1'b1);
    apb_xfer(1'b1, ctrl - 32'h4, 32'h1, 32'h0, 1'b1);
    apb_xfer(1'b0, ctrl + 32'h4, 32'h0, 32'h0, 1'b1);
    apb_xfer(1'b0, 32'h4, 32'h0, 32'h0, 1'b0);
    set_checking(1'b1);
    apb_xfer(1'b1, ctrl, 32'h1, 32'h0, 1'b0);
    wait_frames(3);
    set_checking(1'b0); // frame with live writes not compared
    repeat (4) begin
      rand_bits(aw, w);
      fb_write(int'(w[aw-1:0]), 32'h00ff_0000 ^ w);
    end
    set_checking(1'b1);
    wait_frames(2);
    wait_video(1'b1, "valid pixels");
    set_checking(1'b0);
    apb_xfer(1'b1, ctrl, 32'h0, 32'h0, 1'b0);
    wait_video(1'b0, "idle outputs");
    check_idle(3 * h_total, "while disabled");
    set_checking(1'b1);
    apb_xfer(1'b1, ctrl, 32'h1, 32'h0, 1'b0);
    wait_frames(2);
    finish_run();
  end

endmodule

//--- filelist.f
vga_pkg.sv
apb_fb_regs.sv
frame_buffer.sv
vga_timing.sv
pixel_fetch.sv
vga_top_apb.sv
vga_chk.sv
tb_vga.sv

//--- run.sh
#!/bin/sh
# build and run the vga testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f filelist.f --top-module tb_vga -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vga > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
